// File: logic/rsa_pkg.sv
`default_nettype none

package rsa_pkg;

    // Command code sits in bits 2 to 0 of the host command word
    typedef logic [2:0] cmd_t;

    // Debug value shown on the board LEDs
    typedef logic [3:0] led_t;

    localparam cmd_t CMD_COMPUTE_EXP  = 3'd0;
    localparam cmd_t CMD_COMPUTE_MONT = 3'd1;
    localparam cmd_t CMD_LOAD_MOD     = 3'd2;
    localparam cmd_t CMD_LOAD_R2      = 3'd3;
    localparam cmd_t CMD_LOAD_EXP     = 3'd4;
    localparam cmd_t CMD_READ_RESULT  = 3'd5;

endpackage

`default_nettype wire

// File: logic/operand_if.sv
`timescale 1ns/1ps
`default_nettype none

interface operand_if #(
    parameter int OP_WIDTH = 32
);

    logic [OP_WIDTH-1:0] modulus;
    logic [OP_WIDTH-1:0] r_mod_m;
    logic [OP_WIDTH-1:0] r2_mod_m;
    logic [OP_WIDTH-1:0] exponent;
    logic [OP_WIDTH-1:0] base;

    modport loader (
        output modulus, r_mod_m, r2_mod_m, exponent, base
    );

    // Values stay static while the core runs
    modport core (
        input modulus, r_mod_m, r2_mod_m, exponent, base
    );

endinterface

`default_nettype wire

// File: logic/mont_mul.sv
`timescale 1ns/1ps
`default_nettype none

module mont_mul #(
    parameter int OP_WIDTH = 32
) (
    input  logic                clk,
    input  logic                resetn,
    input  logic                start,
    input  logic [OP_WIDTH-1:0] a,
    input  logic [OP_WIDTH-1:0] b,
    input  logic [OP_WIDTH-1:0] m,
    output logic                busy,
    output logic                done,
    output logic [OP_WIDTH-1:0] p
);

    localparam int CW = $clog2(OP_WIDTH);

    typedef enum logic [1:0] {
        MM_IDLE,
        MM_SCAN,
        MM_FIN
    } state_t;

    state_t              state;
    logic [OP_WIDTH-1:0] a_sh;
    logic [OP_WIDTH:0]   acc;
    logic [OP_WIDTH:0]   acc_in;
    logic                bit_in;
    logic [OP_WIDTH+1:0] sum_ab;
    logic [OP_WIDTH+1:0] sum_m;
    logic [OP_WIDTH+1:0] diff;
    logic [CW-1:0]       cnt;

    assign busy = (state != MM_IDLE);

    // Bit 0 of a is processed on the start edge itself
    always_comb begin
        acc_in = (state == MM_IDLE) ? '0 : acc;
        bit_in = (state == MM_IDLE) ? a[0] : a_sh[0];
        sum_ab = {1'b0, acc_in} + (bit_in ? {2'b00, b} : '0);
        sum_m  = sum_ab + (sum_ab[0] ? {2'b00, m} : '0);
        diff   = {1'b0, acc} - {2'b00, m};
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            state <= MM_IDLE;
            done  <= 1'b0;
        end else begin
            done <= 1'b0;
            case (state)
                MM_IDLE: begin
                    if (start) begin
                        acc   <= sum_m[OP_WIDTH+1:1];
                        a_sh  <= a >> 1;
                        cnt   <= CW'(1);
                        state <= MM_SCAN;
                    end
                end
                MM_SCAN: begin
                    acc  <= sum_m[OP_WIDTH+1:1];
                    a_sh <= a_sh >> 1;
                    cnt  <= cnt + 1'b1;
                    if (cnt == CW'(OP_WIDTH - 1)) begin
                        state <= MM_FIN;
                    end
                end
                MM_FIN: begin
                    // Sum is below 2m, so one subtraction is enough
                    p     <= diff[OP_WIDTH+1] ? acc[OP_WIDTH-1:0] : diff[OP_WIDTH-1:0];
                    done  <= 1'b1;
                    state <= MM_IDLE;
                end
                default: begin
                    state <= MM_IDLE;
                end
            endcase
        end
    end

    // The sequencer waits for done before issuing the next product
    a_no_start_while_busy: assert property (
        @(posedge clk) disable iff (!resetn)
        start |-> !busy
    );

endmodule

`default_nettype wire

// File: logic/mod_exp.sv
`timescale 1ns/1ps
`default_nettype none

module mod_exp #(
    parameter int OP_WIDTH = 32
) (
    input  logic                clk,
    input  logic                resetn,
    input  logic                start,
    input  logic                mont_only,
    operand_if.core             ops,
    output logic                core_done,
    output logic [OP_WIDTH-1:0] result
);

    localparam int IW = $clog2(OP_WIDTH);

    typedef logic [OP_WIDTH-1:0] operand_t;

    typedef enum logic [2:0] {
        ME_IDLE,
        ME_CONV,
        ME_SQR,
        ME_MUL,
        ME_FIN
    } state_t;

    localparam operand_t ONE = operand_t'(1);

    state_t        state;
    operand_t      acc;
    operand_t      mul_b;
    operand_t      base_m;
    operand_t      mul_p;
    logic [IW-1:0] bit_idx;
    logic          last_bit;
    logic          mul_go;
    logic          mul_done;

    // Accumulator doubles as the a input of the multiplier
    mont_mul #(
        .OP_WIDTH(OP_WIDTH)
    ) i_mont_mul (
        .clk    (clk),
        .resetn (resetn),
        .start  (mul_go),
        .a      (acc),
        .b      (mul_b),
        .m      (ops.modulus),
        .busy   (),
        .done   (mul_done),
        .p      (mul_p)
    );

    assign last_bit = (bit_idx == '0);
    assign result   = acc;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            state     <= ME_IDLE;
            mul_go    <= 1'b0;
            core_done <= 1'b0;
        end else begin
            mul_go    <= 1'b0;
            core_done <= 1'b0;
            case (state)
                ME_IDLE: begin
                    if (start) begin
                        acc     <= ops.base;
                        mul_b   <= ops.r2_mod_m;
                        bit_idx <= IW'(OP_WIDTH - 1);
                        mul_go  <= 1'b1;
                        state   <= ME_CONV;
                    end
                end
                ME_CONV: begin
                    if (mul_done && mont_only) begin
                        acc       <= mul_p;
                        core_done <= 1'b1;
                        state     <= ME_IDLE;
                    end else if (mul_done) begin
                        // Accumulator starts at 1 in Montgomery form
                        base_m <= mul_p;
                        acc    <= ops.r_mod_m;
                        mul_b  <= ops.r_mod_m;
                        mul_go <= 1'b1;
                        state  <= ME_SQR;
                    end
                end
                ME_SQR: begin
                    if (mul_done) begin
                        acc    <= mul_p;
                        mul_go <= 1'b1;
                        if (ops.exponent[bit_idx]) begin
                            mul_b <= base_m;
                            state <= ME_MUL;
                        end else if (last_bit) begin
                            mul_b <= ONE;
                            state <= ME_FIN;
                        end else begin
                            mul_b   <= mul_p;
                            bit_idx <= bit_idx - 1'b1;
                        end
                    end
                end
                ME_MUL: begin
                    if (mul_done) begin
                        acc    <= mul_p;
                        mul_go <= 1'b1;
                        if (last_bit) begin
                            mul_b <= ONE;
                            state <= ME_FIN;
                        end else begin
                            mul_b   <= mul_p;
                            bit_idx <= bit_idx - 1'b1;
                            state   <= ME_SQR;
                        end
                    end
                end
                // Product with 1 leaves the Montgomery domain
                ME_FIN: begin
                    if (mul_done) begin
                        acc       <= mul_p;
                        core_done <= 1'b1;
                        state     <= ME_IDLE;
                    end
                end
                default: begin
                    state <= ME_IDLE;
                end
            endcase
        end
    end

    a_core_done_pulse: assert property (
        @(posedge clk) disable iff (!resetn)
        core_done |=> !core_done
    );

endmodule

`default_nettype wire

// File: logic/result_port.sv
`timescale 1ns/1ps
`default_nettype none

module result_port #(
    parameter int OP_WIDTH = 32
) (
    input  logic                  clk,
    input  logic                  resetn,
    input  logic                  core_done,
    input  logic [OP_WIDTH-1:0]   result,
    input  logic                  op_done,
    input  logic                  send_req,
    input  logic                  out_data_ready,
    input  logic                  done_read,
    output logic                  out_data_valid,
    output logic [2*OP_WIDTH-1:0] out_data,
    output logic                  done,
    output logic                  port_free
);

    typedef enum logic [1:0] {
        RP_FREE,
        RP_SEND,
        RP_ACK
    } state_t;

    state_t              state;
    logic [OP_WIDTH-1:0] result_r;

    always_ff @(posedge clk) begin
        if (core_done) begin
            result_r <= result;
        end
    end

    // Send goes through ack, a finished load goes straight to ack
    always_ff @(posedge clk) begin
        if (!resetn) begin
            state <= RP_FREE;
        end else begin
            case (state)
                RP_FREE: begin
                    if (send_req) begin
                        state <= RP_SEND;
                    end else if (op_done) begin
                        state <= RP_ACK;
                    end
                end
                RP_SEND: begin
                    if (out_data_ready) begin
                        state <= RP_ACK;
                    end
                end
                RP_ACK: begin
                    if (done_read) begin
                        state <= RP_FREE;
                    end
                end
                default: begin
                    state <= RP_FREE;
                end
            endcase
        end
    end

    assign out_data_valid = (state == RP_SEND);
    assign done           = (state == RP_ACK);
    assign port_free      = (state == RP_FREE);
    assign out_data       = {{OP_WIDTH{1'b0}}, result_r};

    a_out_data_held: assert property (
        @(posedge clk) disable iff (!resetn)
        out_data_valid && !out_data_ready |=> out_data_valid && $stable(out_data)
    );

endmodule

`default_nettype wire

// File: logic/operand_loader.sv
`timescale 1ns/1ps
`default_nettype none

module operand_loader
    import rsa_pkg::*;
#(
    parameter int OP_WIDTH = 32
) (
    input  logic                  clk,
    input  logic                  resetn,
    input  logic [31:0]           cmd,
    input  logic                  cmd_valid,
    input  logic                  in_data_valid,
    input  logic [2*OP_WIDTH-1:0] in_data,
    input  logic                  core_done,
    input  logic                  port_free,
    output logic                  in_data_ready,
    output logic                  start,
    output logic                  mont_only,
    output logic                  op_done,
    output logic                  send_req,
    output led_t                  leds,
    operand_if.loader             ops
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_LOAD,
        ST_RUN,
        ST_HOLD
    } state_t;

    state_t              state;
    cmd_t                cmd_code;
    cmd_t                load_cmd;
    logic                accept;
    logic [OP_WIDTH-1:0] data_lo;
    logic [OP_WIDTH-1:0] data_hi;

    assign cmd_code = cmd[2:0];
    assign accept   = cmd_valid && port_free && (state == ST_IDLE);
    assign data_lo  = in_data[OP_WIDTH-1:0];
    assign data_hi  = in_data[2*OP_WIDTH-1:OP_WIDTH];

    assign in_data_ready = (state == ST_LOAD);
    assign leds          = {2'b00, state};

    always_ff @(posedge clk) begin
        if (!resetn) begin
            state     <= ST_IDLE;
            start     <= 1'b0;
            mont_only <= 1'b0;
            op_done   <= 1'b0;
            send_req  <= 1'b0;
        end else begin
            start    <= 1'b0;
            op_done  <= 1'b0;
            send_req <= 1'b0;
            case (state)
                ST_IDLE: begin
                    if (accept) begin
                        case (cmd_code)
                            CMD_COMPUTE_EXP, CMD_COMPUTE_MONT: begin
                                mont_only <= (cmd_code == CMD_COMPUTE_MONT);
                                start     <= 1'b1;
                                state     <= ST_RUN;
                            end
                            CMD_LOAD_MOD, CMD_LOAD_R2, CMD_LOAD_EXP: begin
                                state <= ST_LOAD;
                            end
                            CMD_READ_RESULT: begin
                                send_req <= 1'b1;
                                state    <= ST_HOLD;
                            end
                            // Codes 6 and 7 are dropped
                            default: begin
                                state <= ST_IDLE;
                            end
                        endcase
                    end
                end
                ST_LOAD: begin
                    if (in_data_valid) begin
                        op_done <= 1'b1;
                        state   <= ST_HOLD;
                    end
                end
                ST_RUN: begin
                    if (core_done) begin
                        op_done <= 1'b1;
                        state   <= ST_HOLD;
                    end
                end
                // One cycle for the result port to see the pulse and drop port_free
                ST_HOLD: begin
                    state <= ST_IDLE;
                end
                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            load_cmd <= cmd_code;
        end
        if ((state == ST_LOAD) && in_data_valid) begin
            case (load_cmd)
                CMD_LOAD_MOD: begin
                    ops.modulus <= data_lo;
                    ops.r_mod_m <= data_hi;
                end
                CMD_LOAD_R2: begin
                    ops.r2_mod_m <= data_lo;
                    ops.base     <= data_hi;
                end
                CMD_LOAD_EXP: begin
                    ops.exponent <= data_lo;
                end
                default: begin
                end
            endcase
        end
    end

    // No operand word is taken between core start and core completion
    a_no_load_during_run: assert property (
        @(posedge clk) disable iff (!resetn)
        start |-> (!in_data_ready until_with core_done)
    );

endmodule

`default_nettype wire

// File: logic/rsa_top.sv
`timescale 1ns/1ps
`default_nettype none

module rsa_top
    import rsa_pkg::*;
#(
    parameter int OP_WIDTH = 32
) (
    input  logic                  clk,
    input  logic                  resetn,
    input  logic [31:0]           cmd,
    input  logic                  cmd_valid,
    output logic                  done,
    input  logic                  done_read,
    input  logic                  in_data_valid,
    output logic                  in_data_ready,
    input  logic [2*OP_WIDTH-1:0] in_data,
    output logic                  out_data_valid,
    input  logic                  out_data_ready,
    output logic [2*OP_WIDTH-1:0] out_data,
    output led_t                  leds
);

    logic                start;
    logic                mont_only;
    logic                op_done;
    logic                send_req;
    logic                port_free;
    logic                core_done;
    logic [OP_WIDTH-1:0] result;

    operand_if #(
        .OP_WIDTH(OP_WIDTH)
    ) ops ();

    // Input side
    operand_loader #(
        .OP_WIDTH(OP_WIDTH)
    ) i_operand_loader (
        .clk           (clk),
        .resetn        (resetn),
        .cmd           (cmd),
        .cmd_valid     (cmd_valid),
        .in_data_valid (in_data_valid),
        .in_data       (in_data),
        .core_done     (core_done),
        .port_free     (port_free),
        .in_data_ready (in_data_ready),
        .start         (start),
        .mont_only     (mont_only),
        .op_done       (op_done),
        .send_req      (send_req),
        .leds          (leds),
        .ops           (ops.loader)
    );

    mod_exp #(
        .OP_WIDTH(OP_WIDTH)
    ) i_mod_exp (
        .clk       (clk),
        .resetn    (resetn),
        .start     (start),
        .mont_only (mont_only),
        .ops       (ops.core),
        .core_done (core_done),
        .result    (result)
    );

    // Output side
    result_port #(
        .OP_WIDTH(OP_WIDTH)
    ) i_result_port (
        .clk            (clk),
        .resetn         (resetn),
        .core_done      (core_done),
        .result         (result),
        .op_done        (op_done),
        .send_req       (send_req),
        .out_data_ready (out_data_ready),
        .done_read      (done_read),
        .out_data_valid (out_data_valid),
        .out_data       (out_data),
        .done           (done),
        .port_free      (port_free)
    );

endmodule

`default_nettype wire

// File: test/rsa_tb.sv
`timescale 1ns/1ps
`default_nettype none

module rsa_tb
    import rsa_pkg::*;
();

    localparam int OP_WIDTH       = 32;
    localparam int NUM_ROWS       = 8;
    localparam int HALF_PERIOD    = 20;
    localparam int TIMEOUT_CYCLES = NUM_ROWS * (4 * OP_WIDTH * OP_WIDTH + 200);
    localparam int MODE_PLAIN     = 0;
    localparam int MODE_STALL     = 1;
    localparam led_t LEDS_IDLE    = 4'h0;

    typedef logic [OP_WIDTH-1:0]   word_t;
    typedef logic [2*OP_WIDTH-1:0] bus_t;

    logic        clk;
    logic        resetn;
    logic [31:0] cmd;
    logic        cmd_valid;
    logic        done;
    logic        done_read;
    logic        in_data_valid;
    logic        in_data_ready;
    bus_t        in_data;
    logic        out_data_valid;
    logic        out_data_ready;
    bus_t        out_data;
    led_t        leds;

    // Stimulus table with one entry per row in each array
    string row_name [NUM_ROWS];
    word_t row_mod  [NUM_ROWS];
    word_t row_exp  [NUM_ROWS];
    word_t row_base [NUM_ROWS];
    int    row_mode [NUM_ROWS];

    rsa_top #(
        .OP_WIDTH(OP_WIDTH)
    ) i_rsa_top (
        .clk            (clk),
        .resetn         (resetn),
        .cmd            (cmd),
        .cmd_valid      (cmd_valid),
        .done           (done),
        .done_read      (done_read),
        .in_data_valid  (in_data_valid),
        .in_data_ready  (in_data_ready),
        .in_data        (in_data),
        .out_data_valid (out_data_valid),
        .out_data_ready (out_data_ready),
        .out_data       (out_data),
        .leds           (leds)
    );

    initial begin
        clk = 1'b0;
        forever #HALF_PERIOD clk = ~clk;
    end

    initial begin
        repeat (TIMEOUT_CYCLES) @(posedge clk);
        $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("Simulation failed");
        $fatal(1, "Watchdog expired");
    end

    task automatic check_result(input string name, input bus_t expected, input bus_t actual);
        if (actual !== expected) begin
            $display("Error: %s expected %h actual %h", name, expected, actual);
            $display("Simulation failed");
            $fatal(1, "Result mismatch");
        end
    endtask

    task automatic check_leds(input string name, input led_t expected, input led_t actual);
        if (actual !== expected) begin
            $display("Error: %s expected %h actual %h", name, expected, actual);
            $display("Simulation failed");
            $fatal(1, "LED mismatch");
        end
    endtask

    task automatic check_bit(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("Error: %s expected %b actual %b", name, expected, actual);
            $display("Simulation failed");
            $fatal(1, "Handshake mismatch");
        end
    endtask

    // Reference arithmetic in 64 bits
    function automatic word_t r_mod(input word_t m);
        logic [63:0] wide;
        wide = 64'd1 << OP_WIDTH;
        return word_t'(wide % 64'(m));
    endfunction

    function automatic word_t r2_mod(input word_t m);
        logic [63:0] rm;
        rm = 64'(r_mod(m));
        return word_t'((rm * rm) % 64'(m));
    endfunction

    function automatic word_t mont_ref(input word_t b, input word_t m);
        return word_t'((64'(b) << OP_WIDTH) % 64'(m));
    endfunction

    function automatic word_t mod_pow(input word_t b, input word_t e, input word_t m);
        logic [63:0] r;
        logic [63:0] x;
        r = 64'd1 % 64'(m);
        x = 64'(b) % 64'(m);
        for (int i = OP_WIDTH - 1; i >= 0; i--) begin
            r = (r * r) % 64'(m);
            if (e[i]) begin
                r = (r * x) % 64'(m);
            end
        end
        return word_t'(r);
    endfunction

    task automatic set_row(input int idx, input string name, input word_t m, input word_t e,
                           input word_t b, input int mode);
        row_name[idx] = name;
        row_mod[idx]  = m;
        row_exp[idx]  = e;
        row_base[idx] = b;
        row_mode[idx] = mode;
    endtask

    task automatic fill_table();
        word_t m;
        set_row(0, "exp_zero", 32'h7fff_ffed, 32'h0000_0000, 32'h0000_3039, MODE_PLAIN);
        set_row(1, "exp_one", 32'h6a3b_1c27, 32'h0000_0001, 32'h1234_5678, MODE_STALL);
        set_row(2, "exp_all_ones", 32'h7fff_ffff, 32'hffff_ffff, 32'h0000_0003, MODE_PLAIN);
        set_row(3, "base_zero", 32'h0001_0001, 32'h0000_0abc, 32'h0000_0000, MODE_PLAIN);
        set_row(4, "small_mod", 32'h0000_0003, 32'h1234_5677, 32'h0000_0002, MODE_STALL);
        // Random moduli are odd, at least 3 and below 2^31
        for (int i = 5; i < NUM_ROWS; i++) begin
            m = ($urandom & 32'h7fff_fffe) | 32'h1;
            if (m < 32'd3) begin
                m = 32'd3;
            end
            set_row(i, $sformatf("random_%0d", i), m, $urandom, $urandom % m,
                    (i == 5) ? MODE_STALL : int'($urandom % 2));
        end
    endtask

    task automatic send_cmd(input cmd_t code);
        @(negedge clk);
        cmd       = 32'(code);
        cmd_valid = 1'b1;
    endtask

    task automatic send_data(input string name, input bus_t word);
        do begin
            @(negedge clk);
        end while (!in_data_ready);
        in_data_valid = 1'b1;
        in_data       = word;
        @(negedge clk);
        in_data_valid = 1'b0;
        check_bit({name, " ready after capture"}, 1'b0, in_data_ready);
    endtask

    // Waits for done, holds done_read back, then acknowledges
    task automatic wait_done(input string name, input int ack_delay);
        while (!done) begin
            @(negedge clk);
        end
        cmd_valid = 1'b0;
        repeat (ack_delay) begin
            @(negedge clk);
            check_bit({name, " done held"}, 1'b1, done);
        end
        done_read = 1'b1;
        @(negedge clk);
        done_read = 1'b0;
        check_bit({name, " done cleared"}, 1'b0, done);
        check_leds({name, " leds"}, LEDS_IDLE, leds);
    endtask

    task automatic read_result(input string name, input bus_t expected, input int mode);
        bus_t first;
        int   stall;
        int   ack_delay;
        send_cmd(CMD_READ_RESULT);
        while (!out_data_valid) begin
            @(negedge clk);
        end
        first = out_data;
        if (mode == MODE_STALL) begin
            stall = 1 + int'($urandom % 10);
            repeat (stall) begin
                @(negedge clk);
                check_bit({name, " valid held"}, 1'b1, out_data_valid);
                check_bit({name, " done early"}, 1'b0, done);
                check_result({name, " data held"}, first, out_data);
            end
        end
        check_result(name, expected, out_data);
        out_data_ready = 1'b1;
        @(negedge clk);
        out_data_ready = 1'b0;
        check_bit({name, " valid dropped"}, 1'b0, out_data_valid);
        ack_delay = (mode == MODE_STALL) ? 1 + int'($urandom % 10) : 0;
        wait_done(name, ack_delay);
    endtask

    task automatic run_row(input int idx);
        string name;
        word_t m;
        word_t b;
        word_t e;
        name = row_name[idx];
        m    = row_mod[idx];
        b    = row_base[idx];
        e    = row_exp[idx];
        send_cmd(CMD_LOAD_MOD);
        send_data({name, " load_mod"}, {r_mod(m), m});
        wait_done({name, " load_mod"}, 0);
        send_cmd(CMD_LOAD_R2);
        send_data({name, " load_r2"}, {b, r2_mod(m)});
        wait_done({name, " load_r2"}, 0);
        send_cmd(CMD_LOAD_EXP);
        send_data({name, " load_exp"}, {word_t'(0), e});
        wait_done({name, " load_exp"}, 0);
        send_cmd(CMD_COMPUTE_MONT);
        wait_done({name, " mont run"}, 0);
        read_result({name, " mont"}, {word_t'(0), mont_ref(b, m)}, MODE_PLAIN);
        send_cmd(CMD_COMPUTE_EXP);
        wait_done({name, " exp run"}, 0);
        read_result({name, " exp"}, {word_t'(0), mod_pow(b, e, m)}, row_mode[idx]);
    endtask

    // Unused codes must leave the loader idle
    task automatic ignore_cmd(input cmd_t code);
        send_cmd(code);
        repeat (20) begin
            @(negedge clk);
            check_bit("ignored cmd done", 1'b0, done);
            check_bit("ignored cmd in_data_ready", 1'b0, in_data_ready);
            check_leds("ignored cmd leds", LEDS_IDLE, leds);
        end
        cmd_valid = 1'b0;
    endtask

    initial begin
        void'($urandom(32'h504d_465e));
        resetn         = 1'b0;
        cmd            = '0;
        cmd_valid      = 1'b0;
        done_read      = 1'b0;
        in_data_valid  = 1'b0;
        in_data        = '0;
        out_data_ready = 1'b0;
        fill_table();
        repeat (3) @(posedge clk);
        @(negedge clk);
        resetn = 1'b1;
        check_bit("reset done", 1'b0, done);
        check_bit("reset in_data_ready", 1'b0, in_data_ready);
        check_bit("reset out_data_valid", 1'b0, out_data_valid);
        check_leds("reset leds", LEDS_IDLE, leds);

        for (int i = 0; i < NUM_ROWS; i++) begin
            run_row(i);
        end

        ignore_cmd(3'd6);
        ignore_cmd(3'd7);
        // Last row's operands are still loaded
        send_cmd(CMD_COMPUTE_MONT);
        wait_done("after ignored mont run", 0);
        read_result("after ignored mont",
                    {word_t'(0), mont_ref(row_base[NUM_ROWS-1], row_mod[NUM_ROWS-1])},
                    MODE_STALL);

        $display("Simulation passed");
        $finish;
    end

endmodule

`default_nettype wire

// File: build.f
logic/rsa_pkg.sv
logic/operand_if.sv
logic/mont_mul.sv
logic/mod_exp.sv
logic/result_port.sv
logic/operand_loader.sv
logic/rsa_top.sv
test/rsa_tb.sv

// File: Bender.yml
package:
  name: rsa_accel

sources:
  - files:
      - logic/rsa_pkg.sv
      - logic/operand_if.sv
      - logic/mont_mul.sv
      - logic/mod_exp.sv
      - logic/result_port.sv
      - logic/operand_loader.sv
      - logic/rsa_top.sv
  - target: test
    files:
      - test/rsa_tb.sv
